/* rename_pkg.sv */
package rename_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file sizes
  ////////////////////////////////////////////////////////////////////////////

  // Integer physical register file
  localparam int PHYS_REGS = 64;

  // Architectural integer registers
  localparam int ARCH_REGS = 32;

  // Lanes renamed per cycle unless the top level overrides it
  localparam int DEFAULT_RENAME_WIDTH = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Index and bitmap types
  ////////////////////////////////////////////////////////////////////////////

  // Physical register number
  typedef logic [$clog2(PHYS_REGS)-1:0] phys_index_t;

  // Architectural register number
  typedef logic [$clog2(ARCH_REGS)-1:0] arch_index_t;

  // One bit per physical register, 1 means busy
  typedef logic [PHYS_REGS-1:0] phys_bitmap_t;

  // Busy state out of reset, the identity mapping holds the low registers
  localparam phys_bitmap_t RESET_BUSY = phys_bitmap_t'({ARCH_REGS{1'b1}});

endpackage

/* free_list.sv */
module free_list #(
  parameter int RENAME_WIDTH = rename_pkg::DEFAULT_RENAME_WIDTH
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        stall,
  input  logic                                        flush,
  input  rename_pkg::phys_bitmap_t                    recover_bitmap,
  input  logic [RENAME_WIDTH-1:0]                     release_valid,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  release_index,
  input  logic [RENAME_WIDTH-1:0]                     alloc_request,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  alloc_index,
  output logic                                        alloc_ready
);

  localparam int COUNT_BITS = $clog2(rename_pkg::PHYS_REGS + 1);

  typedef logic [COUNT_BITS-1:0] count_t;

  rename_pkg::phys_bitmap_t busy;
  count_t                   free_count;

  rename_pkg::phys_bitmap_t released_busy;
  rename_pkg::phys_bitmap_t alloc_busy;
  count_t                   release_count;
  count_t                   request_count;
  count_t                   free_after_release;
  count_t                   bitmap_free;

  // Number of zero bits in a bitmap
  function automatic count_t count_free(input rename_pkg::phys_bitmap_t map);
    count_t total;
    total = '0;
    for (int i = 0; i < rename_pkg::PHYS_REGS; i++) begin
      if (!map[i]) begin
        total = total + 1'b1;
      end
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Release, then count requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    released_busy = busy;
    release_count = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (release_valid[i]) begin
        released_busy[release_index[i]] = 1'b0;
        release_count = release_count + 1'b1;
      end
    end
  end

  always_comb begin
    request_count = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (alloc_request[i]) begin
        request_count = request_count + 1'b1;
      end
    end
  end

  assign free_after_release = free_count + release_count;
  assign alloc_ready        = request_count <= free_after_release;

  ////////////////////////////////////////////////////////////////////////////
  // Lowest-index pick per requesting lane, in lane order
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic found;
    alloc_busy = released_busy;
    for (int lane = 0; lane < RENAME_WIDTH; lane++) begin
      alloc_index[lane] = '0;
      found = 1'b0;
      if (alloc_request[lane]) begin
        for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
          if (!found && !alloc_busy[p]) begin
            alloc_index[lane] = rename_pkg::phys_index_t'(p);
            alloc_busy[p] = 1'b1;
            found = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= rename_pkg::RESET_BUSY;
      free_count <= count_t'(rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS);
    end else if (flush) begin
      busy       <= recover_bitmap;
      free_count <= count_free(recover_bitmap);
    end else if (!stall && alloc_ready) begin
      busy       <= alloc_busy;
      free_count <= free_after_release - request_count;
    end else begin
      // Group held back, only the commit releases land
      busy       <= released_busy;
      free_count <= free_after_release;
    end
  end

  // Independent count straight from the bitmap
  assign bitmap_free = count_free(released_busy);

  for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_release_check
    assert property (@(posedge clock) disable iff (reset)
      release_valid[i] && !flush |-> busy[release_index[i]])
      else $error("free_list: lane %0d releases free register %0d", i, release_index[i]);
  end

  assert property (@(posedge clock) disable iff (reset)
    alloc_ready |-> request_count <= bitmap_free)
    else $error("free_list: ready with %0d requests, %0d free", request_count, bitmap_free);

endmodule

/* map_table.sv */
module map_table #(
  parameter int RENAME_WIDTH = rename_pkg::DEFAULT_RENAME_WIDTH
) (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                stall,
  input  logic                                                flush,
  input  rename_pkg::phys_index_t [rename_pkg::ARCH_REGS-1:0] recover_map,
  input  logic [RENAME_WIDTH-1:0]                             rename_valid,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]          arch_src1,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]          arch_src2,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]          arch_dest,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          new_phys_dest,
  input  logic                                                accept,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          phys_src1,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          phys_src2,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          old_phys_dest
);

  // Speculative mapping, one entry per architectural register
  rename_pkg::phys_index_t [rename_pkg::ARCH_REGS-1:0] spec_map;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup with forwarding from earlier lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < RENAME_WIDTH; k++) begin
      phys_src1[k]     = spec_map[arch_src1[k]];
      phys_src2[k]     = spec_map[arch_src2[k]];
      old_phys_dest[k] = spec_map[arch_dest[k]];
      // Ascending scan so the latest earlier writer wins
      for (int j = 0; j < k; j++) begin
        if (rename_valid[j] && arch_dest[j] == arch_src1[k]) begin
          phys_src1[k] = new_phys_dest[j];
        end
        if (rename_valid[j] && arch_dest[j] == arch_src2[k]) begin
          phys_src2[k] = new_phys_dest[j];
        end
        if (rename_valid[j] && arch_dest[j] == arch_dest[k]) begin
          old_phys_dest[k] = new_phys_dest[j];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
        spec_map[a] <= rename_pkg::phys_index_t'(a);
      end
    end else if (flush) begin
      spec_map <= recover_map;
    end else if (accept) begin
      // Later lanes overwrite earlier ones to the same register
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (rename_valid[i]) begin
          spec_map[arch_dest[i]] <= new_phys_dest[i];
        end
      end
    end
  end

  // Top level must keep a held or flushed group out of the table
  assert property (@(posedge clock) disable iff (reset)
    accept |-> !flush && !stall)
    else $error("map_table: accept raised during flush or stall");

endmodule

/* commit_map.sv */
module commit_map #(
  parameter int RENAME_WIDTH = rename_pkg::DEFAULT_RENAME_WIDTH
) (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                flush,
  input  logic [RENAME_WIDTH-1:0]                             commit_valid,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]          commit_arch_dest,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          commit_phys_dest,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]          commit_old_phys_dest,
  output rename_pkg::phys_index_t [rename_pkg::ARCH_REGS-1:0] retired_map,
  output rename_pkg::phys_bitmap_t                            retired_bitmap
);

  rename_pkg::phys_index_t [rename_pkg::ARCH_REGS-1:0] map_next;
  rename_pkg::phys_bitmap_t                            bitmap_next;

  ////////////////////////////////////////////////////////////////////////////
  // Retirement in lane order
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    map_next    = retired_map;
    bitmap_next = retired_bitmap;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (commit_valid[i]) begin
        map_next[commit_arch_dest[i]]        = commit_phys_dest[i];
        bitmap_next[commit_phys_dest[i]]     = 1'b1;
        // Previous owner of the register is dead once the new one retires
        bitmap_next[commit_old_phys_dest[i]] = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
        retired_map[a] <= rename_pkg::phys_index_t'(a);
      end
      retired_bitmap <= rename_pkg::RESET_BUSY;
    end else if (!flush) begin
      retired_map    <= map_next;
      retired_bitmap <= bitmap_next;
    end
  end

  // A register allocated by rename is free in the retired view until it commits
  for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_commit_check
    assert property (@(posedge clock) disable iff (reset)
      commit_valid[i] && !flush |-> !retired_bitmap[commit_phys_dest[i]])
      else $error("commit_map: lane %0d commits busy register %0d", i, commit_phys_dest[i]);
  end

endmodule

/* rename_unit.sv */
module rename_unit #(
  parameter int RENAME_WIDTH = rename_pkg::DEFAULT_RENAME_WIDTH
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        stall,
  input  logic                                        flush,

  // Rename group
  input  logic [RENAME_WIDTH-1:0]                     rename_valid,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]  arch_src1,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]  arch_src2,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]  arch_dest,
  output logic                                        rename_ready,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  phys_src1,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  phys_src2,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  phys_dest,
  output rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  old_phys_dest,

  // Commit group from the reorder buffer
  input  logic [RENAME_WIDTH-1:0]                     commit_valid,
  input  rename_pkg::arch_index_t [RENAME_WIDTH-1:0]  commit_arch_dest,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  commit_phys_dest,
  input  rename_pkg::phys_index_t [RENAME_WIDTH-1:0]  commit_old_phys_dest
);

  rename_pkg::phys_index_t [rename_pkg::ARCH_REGS-1:0] retired_map;
  rename_pkg::phys_bitmap_t                            retired_bitmap;
  logic                                                accept;

  // Group enters the speculative state only on a clean edge
  assign accept = rename_ready && !stall && !flush;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  free_list #(
    .RENAME_WIDTH(RENAME_WIDTH)
  ) free_list_inst (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .flush          (flush),
    .recover_bitmap (retired_bitmap),
    .release_valid  (commit_valid),
    .release_index  (commit_old_phys_dest),
    .alloc_request  (rename_valid),
    .alloc_index    (phys_dest),
    .alloc_ready    (rename_ready)
  );

  map_table #(
    .RENAME_WIDTH(RENAME_WIDTH)
  ) map_table_inst (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .flush         (flush),
    .recover_map   (retired_map),
    .rename_valid  (rename_valid),
    .arch_src1     (arch_src1),
    .arch_src2     (arch_src2),
    .arch_dest     (arch_dest),
    .new_phys_dest (phys_dest),
    .accept        (accept),
    .phys_src1     (phys_src1),
    .phys_src2     (phys_src2),
    .old_phys_dest (old_phys_dest)
  );

  commit_map #(
    .RENAME_WIDTH(RENAME_WIDTH)
  ) commit_map_inst (
    .clock                (clock),
    .reset                (reset),
    .flush                (flush),
    .commit_valid         (commit_valid),
    .commit_arch_dest     (commit_arch_dest),
    .commit_phys_dest     (commit_phys_dest),
    .commit_old_phys_dest (commit_old_phys_dest),
    .retired_map          (retired_map),
    .retired_bitmap       (retired_bitmap)
  );

endmodule

/* tb_rename_unit.sv */
module tb_rename_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANES = 2;
  localparam int CLOCK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int RESET_TIMEOUT = 50;
  localparam int MAX_LINES = 1000;
  localparam string CASE_FILE = "rename_cases.txt";

  logic                                clock;
  logic                                reset;
  logic                                stall;
  logic                                flush;
  logic [LANES-1:0]                    rename_valid;
  rename_pkg::arch_index_t [LANES-1:0] arch_src1;
  rename_pkg::arch_index_t [LANES-1:0] arch_src2;
  rename_pkg::arch_index_t [LANES-1:0] arch_dest;
  logic                                rename_ready;
  rename_pkg::phys_index_t [LANES-1:0] phys_src1;
  rename_pkg::phys_index_t [LANES-1:0] phys_src2;
  rename_pkg::phys_index_t [LANES-1:0] phys_dest;
  rename_pkg::phys_index_t [LANES-1:0] old_phys_dest;
  logic [LANES-1:0]                    commit_valid;
  rename_pkg::arch_index_t [LANES-1:0] commit_arch_dest;
  rename_pkg::phys_index_t [LANES-1:0] commit_phys_dest;
  rename_pkg::phys_index_t [LANES-1:0] commit_old_phys_dest;

  // One parsed line of the case file
  // Expected columns set to -1 are not checked
  string case_name;
  int    stall_sel;
  int    flush_in;
  int    rvalid_in;
  int    cvalid_in;
  int    src1_in [LANES];
  int    src2_in [LANES];
  int    dest_in [LANES];
  int    carch_in [LANES];
  int    cphys_in [LANES];
  int    cold_in [LANES];
  int    ready_exp;
  int    pdest_exp [LANES];
  int    psrc1_exp [LANES];
  int    psrc2_exp [LANES];
  int    oldp_exp [LANES];

  int error_count;
  int check_count;
  int cycles;

  rename_unit #(
    .RENAME_WIDTH(LANES)
  ) rename_unit_inst (
    .clock                (clock),
    .reset                (reset),
    .stall                (stall),
    .flush                (flush),
    .rename_valid         (rename_valid),
    .arch_src1            (arch_src1),
    .arch_src2            (arch_src2),
    .arch_dest            (arch_dest),
    .rename_ready         (rename_ready),
    .phys_src1            (phys_src1),
    .phys_src2            (phys_src2),
    .phys_dest            (phys_dest),
    .old_phys_dest        (old_phys_dest),
    .commit_valid         (commit_valid),
    .commit_arch_dest     (commit_arch_dest),
    .commit_phys_dest     (commit_phys_dest),
    .commit_old_phys_dest (commit_old_phys_dest)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // Reset released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    stall                = 1'b0;
    flush                = 1'b0;
    rename_valid         = '0;
    arch_src1            = '0;
    arch_src2            = '0;
    arch_dest            = '0;
    commit_valid         = '0;
    commit_arch_dest     = '0;
    commit_phys_dest     = '0;
    commit_old_phys_dest = '0;
  endtask

  task automatic drive_case();
    // Code 2 leaves the stall to the random generator
    if (stall_sel == 2) begin
      stall = 1'($urandom % 2);
    end else begin
      stall = 1'(stall_sel);
    end
    flush = 1'(flush_in);
    for (int i = 0; i < LANES; i++) begin
      rename_valid[i]         = rvalid_in[i];
      arch_src1[i]            = rename_pkg::arch_index_t'(src1_in[i]);
      arch_src2[i]            = rename_pkg::arch_index_t'(src2_in[i]);
      arch_dest[i]            = rename_pkg::arch_index_t'(dest_in[i]);
      commit_valid[i]         = cvalid_in[i];
      commit_arch_dest[i]     = rename_pkg::arch_index_t'(carch_in[i]);
      commit_phys_dest[i]     = rename_pkg::phys_index_t'(cphys_in[i]);
      commit_old_phys_dest[i] = rename_pkg::phys_index_t'(cold_in[i]);
    end
  endtask

  task automatic compare_field(input string field, input int expected, input int actual);
    if (expected >= 0) begin
      check_count++;
      if (actual != expected) begin
        $display("FAIL %s %s expected %0d actual %0d", case_name, field, expected, actual);
        error_count++;
      end
    end
  endtask

  task automatic check_outputs();
    compare_field("rename_ready", ready_exp, int'(rename_ready));
    for (int i = 0; i < LANES; i++) begin
      compare_field($sformatf("phys_dest[%0d]", i), pdest_exp[i], int'(phys_dest[i]));
      compare_field($sformatf("phys_src1[%0d]", i), psrc1_exp[i], int'(phys_src1[i]));
      compare_field($sformatf("phys_src2[%0d]", i), psrc2_exp[i], int'(phys_src2[i]));
      compare_field($sformatf("old_phys_dest[%0d]", i), oldp_exp[i], int'(old_phys_dest[i]));
    end
  endtask

  // One case line per cycle from a falling edge
  task automatic run_cases();
    int    fd;
    int    fields;
    int    line_count;
    int    got;
    bit    seen_end;
    string line;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CASE_FILE);
      error_count++;
    end else begin
      seen_end   = 1'b0;
      line_count = 0;
      while (!seen_end && !$feof(fd) && line_count < MAX_LINES) begin
        line_count++;
        line = "";
        got  = $fgets(line, fd);
        // Skip blank lines and comments
        if (got > 1 && line.getc(0) != "#") begin
          case_name = "";
          fields = $sscanf(line,
            "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
            case_name, stall_sel, flush_in, rvalid_in,
            src1_in[0], src2_in[0], dest_in[0], src1_in[1], src2_in[1], dest_in[1],
            cvalid_in, carch_in[0], cphys_in[0], cold_in[0],
            carch_in[1], cphys_in[1], cold_in[1], ready_exp,
            pdest_exp[0], psrc1_exp[0], psrc2_exp[0], oldp_exp[0],
            pdest_exp[1], psrc1_exp[1], psrc2_exp[1], oldp_exp[1]);
          if (case_name == "end") begin
            seen_end = 1'b1;
          end else if (fields != 26) begin
            $display("Case file line %0d has %0d fields instead of 26", line_count, fields);
            error_count++;
          end else begin
            drive_case();
            // Sample shortly before the rising edge
            #(CLOCK_PERIOD / 2 - 5);
            check_outputs();
            @(posedge clock);
            @(negedge clock);
          end
        end
      end
      $fclose(fd);
      if (!seen_end) begin
        $display("Case file ended without an end line");
        error_count++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h2c4a));
    drive_idle();

    cycles = 0;
    while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end

    if (reset !== 1'b0) begin
      $display("Timeout while waiting for reset to be released");
      error_count++;
    end else begin
      @(negedge clock);
      run_cases();
      drive_idle();
    end

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* rename_cases.txt */
# name stall flush rvalid  l0: src1 src2 dest  l1: src1 src2 dest  cvalid  l0: arch phys old  l1: arch phys old
# ready  l0: pdest psrc1 psrc2 oldp  l1: pdest psrc1 psrc2 oldp  (stall 2 = random, -1 = not checked)
alloc_a 0 0 3 1 2 3 4 5 6 0 0 0 0 0 0 0 1 32 1 2 3 33 4 5 6
fwd 0 0 3 3 6 7 7 3 7 0 0 0 0 0 0 0 1 34 32 33 7 35 34 32 34
fill_01 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 36 10 11 10 37 36 11 11
fill_02 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 38 36 37 36 39 38 37 37
fill_03 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 40 38 39 38 41 40 39 39
fill_04 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 42 40 41 40 43 42 41 41
fill_05 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 44 42 43 42 45 44 43 43
fill_06 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 46 44 45 44 47 46 45 45
fill_07 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 48 46 47 46 49 48 47 47
fill_08 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 50 48 49 48 51 50 49 49
fill_09 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 52 50 51 50 53 52 51 51
fill_10 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 54 52 53 52 55 54 53 53
fill_11 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 56 54 55 54 57 56 55 55
fill_12 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 58 56 57 56 59 58 57 57
fill_13 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 60 58 59 58 61 60 59 59
fill_14 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 1 62 60 61 60 63 62 61 61
full 0 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 0 -1 62 63 62 -1 -1 63 63
full_stall 1 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 0 -1 62 63 62 -1 -1 63 63
full_dc 2 0 3 10 11 10 10 11 11 0 0 0 0 0 0 0 0 -1 62 63 62 -1 -1 63 63
commit_a 0 0 3 10 11 10 10 11 11 3 3 32 3 6 33 6 1 3 62 63 62 6 3 63 63
commit_b 0 0 3 10 11 10 10 11 11 3 7 34 7 7 35 34 1 7 3 6 3 34 7 6 6
commit_c 2 0 0 0 0 0 0 0 0 3 10 36 10 11 37 11 1 -1 0 0 0 -1 0 0 0
reuse 0 0 1 10 11 12 0 0 0 0 0 0 0 0 0 0 1 10 7 34 12 -1 0 0 0
flush_a 0 1 1 10 11 13 0 0 0 0 0 0 0 0 0 0 1 11 7 34 13 -1 0 0 0
after_flush_a 0 0 3 3 7 10 10 11 13 0 0 0 0 0 0 0 1 3 32 35 36 6 3 37 13
after_flush_b 0 0 3 13 12 12 12 6 1 0 0 0 0 0 0 0 1 7 6 12 12 10 7 33 1
end

/* sources.f */
rename_pkg.sv
free_list.sv
map_table.sv
commit_map.sv
rename_unit.sv
tb_rename_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide on the pass line in the log

rm -f sim.log

verilator --binary --timing --assert --top-module tb_rename_unit -f sources.f \
  -o sim_rename && ./obj_dir/sim_rename > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "No errors" sim.log && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
